// File: Makefile
# Verilator build and run of the AHB matrix output stage testbench

TOP := tb_ahb_mtx_output_stage

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f ahb_mtx_output_stage.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: ahb_mtx_output_stage.f
rtl/ahb_mtx_pkg.sv
rtl/ahb_output_arbiter.sv
rtl/ahb_addr_phase_stage.sv
rtl/ahb_data_phase_stage.sv
rtl/ahb_mtx_output_stage.sv
dv/ahb_mtx_output_stage_assert.sv
dv/tb_ahb_mtx_output_stage.sv

// File: dv/ahb_mtx_output_stage_assert.sv
/*
 * Concurrent checks on the AHB matrix output stage
 *   one-hot active feedback and HREADY after reset
 *   address/control held under wait states
 */

`timescale 1ns/100ps

module ahb_mtx_output_stage_assert #(
  parameter int NUM_PORTS = 3
) (
  input logic                        HCLK,         // AHB clock
  input logic                        HRESETn,      // Sync reset, active low
  input ahb_mtx_pkg::ahb_addr_ctrl_t i_ctrl,       // Slave address/control
  input logic [NUM_PORTS-1:0]        i_active,     // Port active feedback
  input logic                        i_hreadymux   // Muxed HREADY
);

  // At most one port owns the address phase
  a_active_onehot : assert property (
    @(posedge HCLK) disable iff (!HRESETn) $onehot0(i_active))
    else $error("o_active has more than one bit set: %b", i_active);

  // No data phase pending out of reset
  a_ready_after_reset : assert property (
    @(posedge HCLK) $rose(HRESETn) |-> i_hreadymux)
    else $error("o_hreadymux low in the first cycle after reset");

  // Wait state freezes the address phase
  a_ctrl_stable : assert property (
    @(posedge HCLK) disable iff (!HRESETn) !i_hreadymux |=> $stable(i_ctrl))
    else $error("o_ctrl changed during a wait state");

endmodule

bind ahb_mtx_output_stage ahb_mtx_output_stage_assert #(
  .NUM_PORTS   (NUM_PORTS)
) u_assert (
  .HCLK        (HCLK),
  .HRESETn     (HRESETn),
  .i_ctrl      (o_ctrl),
  .i_active    (o_active),
  .i_hreadymux (o_hreadymux)
);

// File: dv/tb_ahb_mtx_output_stage.sv
/*
 * Testbench of the AHB matrix output stage
 *   clock, reset and port drivers
 *   directed tests with one compare task and a result summary
 */

`timescale 1ns/100ps

module tb_ahb_mtx_output_stage;

  localparam int NUM_PORTS  = 3;                    // Same value as the DUT default
  localparam int WAIT_LIMIT = 64;                   // Cycles before a wait gives up

  logic                           HCLK;
  logic                           HRESETn;
  ahb_mtx_pkg::ahb_addr_ctrl_t    port_ctrl [NUM_PORTS]; // Port address/control
  logic                           held_tran [NUM_PORTS]; // Port holds a transfer
  logic [ahb_mtx_pkg::DATA_W-1:0] wdata [NUM_PORTS];     // Port write data
  logic                           hreadyout;             // Slave ready
  ahb_mtx_pkg::ahb_addr_ctrl_t    ctrl;
  logic [NUM_PORTS-1:0]           active;
  logic [ahb_mtx_pkg::DATA_W-1:0] hwdata;
  logic                           hreadymux;

  string test_name;                                 // Test now running
  int    test_errs;                                 // Mismatches in this test
  int    total_errs;
  int    tests_run;
  int    tests_bad;

  ahb_mtx_output_stage #(
    .NUM_PORTS   (NUM_PORTS)
  ) dut0 (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_port_ctrl (port_ctrl),
    .i_held_tran (held_tran),
    .i_wdata     (wdata),
    .i_hreadyout (hreadyout),
    .o_ctrl      (ctrl),
    .o_active    (active),
    .o_hwdata    (hwdata),
    .o_hreadymux (hreadymux)
  );

  initial
  begin : p_clk
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;                        // 4 ns period
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic ahb_mtx_pkg::ahb_addr_ctrl_t make_ctrl(input int port,
    input ahb_mtx_pkg::trans_t trans, input logic [2:0] burst, input logic lock);
    ahb_mtx_pkg::ahb_addr_ctrl_t c;
    c          = '0;
    c.sel      = 1'b1;
    c.addr     = $urandom() & 32'hffff_fffc;        // Word aligned
    c.trans    = trans;
    c.write    = 1'b1;
    c.size     = 3'b010;                            // 32-bit beat
    c.burst    = burst;
    c.prot     = 4'b0011;
    c.master   = 4'(port);                          // Tags the source port
    c.mastlock = lock;
    return c;
  endfunction

  task automatic drive_request(input int port, input ahb_mtx_pkg::trans_t trans,
                               input logic [2:0] burst, input logic lock);
    port_ctrl[port] <= make_ctrl(port, trans, burst, lock);
    held_tran[port] <= 1'b1;
    wdata[port]     <= $urandom();
  endtask

  task automatic apply_reset();
    @(posedge HCLK);
    HRESETn   <= 1'b0;
    hreadyout <= 1'b1;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      port_ctrl[p] <= '0;
      held_tran[p] <= 1'b0;
      wdata[p]     <= '0;
    end
    repeat (8) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
  endtask

  // Rotation picks the first requester after the last grant with wrap
  function automatic int next_in_rotation(input int last, input logic [NUM_PORTS-1:0] mask);
    int idx;
    next_in_rotation = last;
    for (int k = NUM_PORTS; k >= 1; k--)
    begin
      idx = (last + k) % NUM_PORTS;
      if (mask[idx])
        next_in_rotation = idx;                     // Nearest one is found last
    end
  endfunction

  task automatic abort_run(input string why);
    $display("timeout in %s: %s", test_name, why);
    $display("tests failed");
    $finish;
  endtask

  // Called at a falling edge and returns at the next accepting rising edge
  task automatic wait_accept();
    int cycles;
    cycles = 0;
    while (!hreadymux && cycles < WAIT_LIMIT)
    begin
      @(negedge HCLK);
      cycles++;
    end
    if (hreadymux)
      @(posedge HCLK);
    else
      abort_run("o_hreadymux stayed low too long");
  endtask

  // ----------------------------------------
  // Checking and reporting
  // ----------------------------------------
  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic check_grant(input int port);
    check_value("active", 64'(1 << port), 64'(active));
    check_value("ctrl", {11'd0, port_ctrl[port]}, {11'd0, ctrl}); // Live inputs of owner
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    apply_reset();
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0)
      tests_bad++;
    $display("test %s finished with %0d mismatches", test_name, test_errs);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset();
    start_test("reset");
    check_value("active", 64'd0, 64'(active));
    check_value("sel", 64'd0, 64'(ctrl.sel));
    check_value("trans", 64'(ahb_mtx_pkg::TRANS_IDLE), 64'(ctrl.trans));
    check_value("hreadymux", 64'd1, 64'(hreadymux));
    end_test();
  endtask

  task automatic test_single_port();
    start_test("single_port");
    @(posedge HCLK);
    drive_request(1, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_SINGLE, 1'b0);
    @(negedge HCLK);
    check_value("active before grant", 64'd0, 64'(active));
    wait_accept();
    @(negedge HCLK);
    check_grant(1);
    end_test();
  endtask

  task automatic test_round_robin();
    int last;
    int want;
    start_test("round_robin");
    @(posedge HCLK);
    for (int p = 0; p < NUM_PORTS; p++)
      drive_request(p, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_SINGLE, 1'b0);
    @(negedge HCLK);
    last = NUM_PORTS - 1;                           // Pointer after reset
    repeat (3 * NUM_PORTS)
    begin
      wait_accept();
      @(negedge HCLK);
      want = next_in_rotation(last, '1);
      check_grant(want);
      last = want;
    end
    end_test();
  endtask

  task automatic test_wait_states();
    ahb_mtx_pkg::ahb_addr_ctrl_t    ctrl_held;
    logic [ahb_mtx_pkg::DATA_W-1:0] data_held;
    int                             n;
    start_test("wait_states");
    @(posedge HCLK);
    drive_request(2, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_SINGLE, 1'b0);
    @(negedge HCLK);
    wait_accept();                                  // Address phase of port 2
    @(negedge HCLK);
    check_grant(2);
    wait_accept();                                  // Port 2 enters data phase
    hreadyout <= 1'b0;
    drive_request(0, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_SINGLE, 1'b0);
    n = $urandom_range(6, 2);
    @(negedge HCLK);
    check_value("hwdata", 64'(wdata[2]), 64'(hwdata));
    ctrl_held = port_ctrl[2];                       // Owner's inputs stay on the bus
    data_held = wdata[2];
    repeat (n)
    begin
      check_value("hreadymux low", 64'd0, 64'(hreadymux));
      check_value("ctrl held", {11'd0, ctrl_held}, {11'd0, ctrl});
      check_value("hwdata held", 64'(data_held), 64'(hwdata));
      check_value("active held", 64'(1 << 2), 64'(active)); // Port 0 must wait
      @(posedge HCLK);
      @(negedge HCLK);
    end
    @(posedge HCLK);
    hreadyout <= 1'b1;
    @(negedge HCLK);
    check_value("hreadymux high", 64'd1, 64'(hreadymux));
    wait_accept();
    @(negedge HCLK);
    check_grant(next_in_rotation(2, '1));
    end_test();
  endtask

  task automatic test_locked_sequence();
    start_test("locked_sequence");
    @(posedge HCLK);
    drive_request(0, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_SINGLE, 1'b1);
    drive_request(1, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_SINGLE, 1'b0);
    drive_request(2, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_SINGLE, 1'b0);
    @(negedge HCLK);
    repeat (3)
    begin
      wait_accept();
      @(negedge HCLK);
      check_grant(0);
    end
    wait_accept();
    port_ctrl[0].sel <= 1'b0;                       // Another slave with lock kept
    repeat (2)
    begin
      @(negedge HCLK);
      check_grant(0);
      wait_accept();
    end
    port_ctrl[0].sel <= 1'b1;                       // Back to this slave
    @(negedge HCLK);
    check_grant(0);
    wait_accept();
    port_ctrl[0].mastlock <= 1'b0;                  // Last beat of sequence
    @(negedge HCLK);
    check_grant(0);
    wait_accept();
    @(negedge HCLK);
    check_grant(next_in_rotation(0, '1));
    end_test();
  endtask

  task automatic test_burst_hold();
    logic [NUM_PORTS-1:0] mask;
    start_test("burst_hold");
    @(posedge HCLK);
    drive_request(0, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_SINGLE, 1'b0);
    drive_request(1, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_INCR4, 1'b0);
    drive_request(2, ahb_mtx_pkg::TRANS_NONSEQ, ahb_mtx_pkg::BURST_SINGLE, 1'b0);
    @(negedge HCLK);
    wait_accept();
    @(negedge HCLK);
    check_grant(0);
    wait_accept();
    @(negedge HCLK);
    check_grant(1);                                 // First beat
    repeat (3)
    begin
      wait_accept();
      port_ctrl[1].trans <= ahb_mtx_pkg::TRANS_SEQ;
      port_ctrl[1].addr  <= port_ctrl[1].addr + 4;
      @(negedge HCLK);
      check_grant(1);
    end
    wait_accept();                                  // Fourth beat taken
    port_ctrl[1].trans <= ahb_mtx_pkg::TRANS_IDLE;
    held_tran[1]       <= 1'b0;
    @(negedge HCLK);
    check_grant(1);                                 // SEQ beat still owned the bus
    wait_accept();
    @(negedge HCLK);
    mask    = '1;
    mask[1] = 1'b0;
    check_grant(next_in_rotation(1, mask));
    end_test();
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin : p_main
    void'($urandom(32'h83265887));
    HRESETn    = 1'b0;
    hreadyout  = 1'b1;
    total_errs = 0;
    tests_run  = 0;
    tests_bad  = 0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      port_ctrl[p] = '0;
      held_tran[p] = 1'b0;
      wdata[p]     = '0;
    end
    test_reset();
    test_single_port();
    test_round_robin();
    test_wait_states();
    test_locked_sequence();
    test_burst_hold();
    $display("summary: %0d tests run, %0d with mismatches, %0d mismatches in all",
             tests_run, tests_bad, total_errs);
    if (tests_bad == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: rtl/ahb_addr_phase_stage.sv
/*
 * Address phase of the AHB matrix output stage
 *   address/control multiplexer onto the shared slave
 *   one-hot active decode back to the ports
 *   locked-sequence tracking and qualified lock for arbitration
 */

`timescale 1ns/100ps

module ahb_addr_phase_stage #(
  parameter  int NUM_PORTS = 3,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                        HCLK,                    // AHB clock
  input  logic                        HRESETn,                 // Sync reset, active low
  input  logic                        i_hreadymux,             // Transfer accepted
  input  ahb_mtx_pkg::ahb_addr_ctrl_t i_port_ctrl [NUM_PORTS], // Port address/control
  input  logic [PORT_W-1:0]           i_addr_in_port,          // Granted port
  input  logic                        i_no_port,               // No port granted
  output ahb_mtx_pkg::ahb_addr_ctrl_t o_ctrl,                  // Slave address/control
  output logic [NUM_PORTS-1:0]        o_active,                // Port owns address phase
  output logic                        o_lock_arb               // Lock seen by arbiter
);

  logic hsel_lock;      // Locked sequence in progress
  logic next_hsel_lock; // Pre-registered hsel_lock
  logic lock_start;     // Locked transfer selected here

  // ----------------------------------------
  // Address mux and active decode
  // ----------------------------------------
  always_comb
  begin : p_addr_mux
    o_ctrl   = '0;                                  // Idle, unselected default
    o_active = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (!i_no_port && (i_addr_in_port == PORT_W'(p)))
      begin
        o_ctrl      = i_port_ctrl[p];               // Live port inputs
        o_active[p] = 1'b1;                         // One-hot feedback
      end
    end
  end

  // ----------------------------------------
  // Locked-sequence tracking
  // ----------------------------------------
  // A master may address another slave mid-sequence with HSEL low here
  // while keeping HMASTLOCK high, so the lock is remembered until released
  assign lock_start = o_ctrl.sel & o_ctrl.mastlock &
                      ((o_ctrl.trans == ahb_mtx_pkg::TRANS_NONSEQ) |
                       (o_ctrl.trans == ahb_mtx_pkg::TRANS_SEQ));

  always_comb
  begin : p_next_lock
    if (lock_start)
      next_hsel_lock = 1'b1;                        // Sequence begins
    else if (!o_ctrl.mastlock)
      next_hsel_lock = 1'b0;                        // Sequence ends
    else
      next_hsel_lock = hsel_lock;
  end

  always_ff @(posedge HCLK)
  begin : p_hsel_lock
    if (!HRESETn)
      hsel_lock <= 1'b0;
    else if (i_hreadymux)                           // Only on accepted phase
      hsel_lock <= next_hsel_lock;
  end

  // Mastlock masked when unselected unless already locked through here
  assign o_lock_arb = o_ctrl.mastlock & (hsel_lock | o_ctrl.sel);

endmodule

// File: rtl/ahb_data_phase_stage.sv
/*
 * Data phase of the AHB matrix output stage
 *   data-phase port and slave-select registers
 *   write-data multiplexer and HREADY generation
 */

`timescale 1ns/100ps

module ahb_data_phase_stage #(
  parameter  int NUM_PORTS = 3,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                             HCLK,                // AHB clock
  input  logic                             HRESETn,             // Sync reset, active low
  input  logic [ahb_mtx_pkg::DATA_W-1:0]   i_wdata [NUM_PORTS], // Port write data
  input  logic [PORT_W-1:0]                i_addr_in_port,      // Address-phase port
  input  logic                             i_hsel,              // Address-phase HSEL
  input  logic                             i_hreadyout,         // Slave ready
  output logic [ahb_mtx_pkg::DATA_W-1:0]   o_hwdata,            // Slave write data
  output logic                             o_hreadymux          // Muxed HREADY
);

  logic [PORT_W-1:0] data_in_port; // Port owning data phase
  logic              slave_sel;    // Slave selected in data phase

  // ----------------------------------------
  // Data-phase registers
  // ----------------------------------------
  // Address phase moves to data phase only when accepted
  always_ff @(posedge HCLK)
  begin : p_data_regs
    if (!HRESETn)
    begin
      data_in_port <= '0;
      slave_sel    <= 1'b0;                         // Ready is 1 out of reset
    end
    else if (o_hreadymux)
    begin
      data_in_port <= i_addr_in_port;
      slave_sel    <= i_hsel;
    end
  end

  // ----------------------------------------
  // Write-data mux
  // ----------------------------------------
  always_comb
  begin : p_data_mux
    o_hwdata = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (data_in_port == PORT_W'(p))
        o_hwdata = i_wdata[p];                      // Registered port's data
    end
  end

  // ----------------------------------------
  // HREADY generation
  // ----------------------------------------
  // Slave's own ready while it holds a data phase, else always ready
  assign o_hreadymux = slave_sel ? i_hreadyout : 1'b1;

endmodule

// File: rtl/ahb_mtx_output_stage.sv
/*
 * Output stage of an AHB bus matrix
 *   routes the granted input port onto one shared slave
 *   arbiter, address-phase stage and data-phase stage
 */

`timescale 1ns/100ps

module ahb_mtx_output_stage #(
  parameter  int NUM_PORTS = 3,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                           HCLK,                    // AHB clock
  input  logic                           HRESETn,                 // Sync reset, active low
  input  ahb_mtx_pkg::ahb_addr_ctrl_t    i_port_ctrl [NUM_PORTS], // Port address/control
  input  logic                           i_held_tran [NUM_PORTS], // Port holds a transfer
  input  logic [ahb_mtx_pkg::DATA_W-1:0] i_wdata [NUM_PORTS],     // Port write data
  input  logic                           i_hreadyout,             // Slave ready
  output ahb_mtx_pkg::ahb_addr_ctrl_t    o_ctrl,                  // Slave address/control
  output logic [NUM_PORTS-1:0]           o_active,                // Port active feedback
  output logic [ahb_mtx_pkg::DATA_W-1:0] o_hwdata,                // Slave write data
  output logic                           o_hreadymux              // Muxed HREADY
);

  logic [PORT_W-1:0] addr_in_port;         // Granted port
  logic              no_port;              // Nothing granted
  logic              lock_arb;             // Qualified lock
  logic              hreadymux;            // Internal HREADY
  logic              port_sel [NUM_PORTS]; // Per-port HSEL

  // ----------------------------------------
  // Port selects for arbitration
  // ----------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_port_sel
    assign port_sel[p] = i_port_ctrl[p].sel;
  end

  // Arbiter, owner state taken from the muxed control
  ahb_output_arbiter #(
    .NUM_PORTS      (NUM_PORTS)
  ) u_output_arb (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_hreadymux    (hreadymux),
    .i_sel          (port_sel),
    .i_held_tran    (i_held_tran),
    .i_owner_ctrl   (o_ctrl),
    .i_lock_arb     (lock_arb),
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  // Address phase mux and lock tracking
  ahb_addr_phase_stage #(
    .NUM_PORTS      (NUM_PORTS)
  ) u_addr_stage (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_hreadymux    (hreadymux),
    .i_port_ctrl    (i_port_ctrl),
    .i_addr_in_port (addr_in_port),
    .i_no_port      (no_port),
    .o_ctrl         (o_ctrl),
    .o_active       (o_active),
    .o_lock_arb     (lock_arb)
  );

  // Data phase mux and HREADY
  ahb_data_phase_stage #(
    .NUM_PORTS      (NUM_PORTS)
  ) u_data_stage (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_wdata        (i_wdata),
    .i_addr_in_port (addr_in_port),
    .i_hsel         (o_ctrl.sel),
    .i_hreadyout    (i_hreadyout),
    .o_hwdata       (o_hwdata),
    .o_hreadymux    (hreadymux)
  );

  assign o_hreadymux = hreadymux;                   // To slave and ports

endmodule

// File: rtl/ahb_mtx_pkg.sv
/*
 * Shared definitions for the AHB matrix output stage
 *   bus widths
 *   HTRANS transfer codes and HBURST burst codes
 *   packed address-phase control struct of one port
 */

package ahb_mtx_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int ADDR_W = 32;                 // HADDR width
  localparam int DATA_W = 32;                 // HWDATA width

  // ----------------------------------------
  // Transfer and burst codes
  // ----------------------------------------
  typedef enum logic [1:0]
  {
    TRANS_IDLE   = 2'b00,                     // No transfer
    TRANS_BUSY   = 2'b01,                     // Burst paused by master
    TRANS_NONSEQ = 2'b10,                     // First beat or single
    TRANS_SEQ    = 2'b11                      // Following burst beat
  } trans_t;

  localparam logic [2:0] BURST_SINGLE = 3'b000; // Single transfer
  localparam logic [2:0] BURST_INCR4  = 3'b011; // Four-beat incrementing

  // ----------------------------------------
  // Address-phase control of one port
  // ----------------------------------------
  // Field order follows the AHB signal list, sel in the top bit
  typedef struct packed
  {
    logic              sel;                   // HSEL
    logic [ADDR_W-1:0] addr;                  // HADDR
    trans_t            trans;                 // HTRANS
    logic              write;                 // HWRITE
    logic [2:0]        size;                  // HSIZE
    logic [2:0]        burst;                 // HBURST
    logic [3:0]        prot;                  // HPROT
    logic [3:0]        master;                // HMASTER id
    logic              mastlock;              // HMASTLOCK
  } ahb_addr_ctrl_t;

endpackage

// File: rtl/ahb_output_arbiter.sv
/*
 * Round-robin arbiter of the AHB matrix output stage
 *   request forming from sel and held transfer
 *   owner hold for locked sequences and unfinished bursts
 *   registered grant index and no-port flag
 */

`timescale 1ns/100ps

module ahb_output_arbiter #(
  parameter  int NUM_PORTS = 3,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                        HCLK,            // AHB clock
  input  logic                        HRESETn,         // Sync reset, active low
  input  logic                        i_hreadymux,     // Transfer accepted
  input  logic                        i_sel [NUM_PORTS],       // Port HSEL
  input  logic                        i_held_tran [NUM_PORTS], // Port holds a transfer
  input  ahb_mtx_pkg::ahb_addr_ctrl_t i_owner_ctrl,    // Current owner's control
  input  logic                        i_lock_arb,      // Qualified lock of owner
  output logic [PORT_W-1:0]           o_addr_in_port,  // Granted port index
  output logic                        o_no_port        // No port granted
);

  logic [NUM_PORTS-1:0] req;          // Per-port request
  logic                 burst_hold;   // Owner is mid-burst
  logic                 keep_owner;   // Grant stays with owner
  logic [PORT_W-1:0]    rr_port;      // Round-robin winner
  logic                 rr_found;     // Any request seen
  logic [PORT_W-1:0]    next_port;    // Pre-registered grant
  logic                 next_no_port; // Pre-registered no-port

  // ----------------------------------------
  // Requests and hold conditions
  // ----------------------------------------
  always_comb
  begin : p_req
    for (int p = 0; p < NUM_PORTS; p++)
      req[p] = i_sel[p] & i_held_tran[p];           // Selected and holding
  end

  // BUSY or SEQ means more beats follow, NONSEQ of a burst starts one
  assign burst_hold = (i_owner_ctrl.trans == ahb_mtx_pkg::TRANS_BUSY) |
                      (i_owner_ctrl.trans == ahb_mtx_pkg::TRANS_SEQ) |
                      ((i_owner_ctrl.trans == ahb_mtx_pkg::TRANS_NONSEQ) &
                       (i_owner_ctrl.burst != ahb_mtx_pkg::BURST_SINGLE));

  // Locked owner keeps the grant even while its HSEL is low
  assign keep_owner = ~o_no_port & (i_lock_arb | burst_hold);

  // ----------------------------------------
  // Round-robin search
  // ----------------------------------------
  // Starts one past the last granted port and wraps
  always_comb
  begin : p_rr_search
    int idx;
    rr_port  = o_addr_in_port;                      // Default keeps pointer
    rr_found = 1'b0;
    for (int off = 1; off <= NUM_PORTS; off++)
    begin
      idx = int'(o_addr_in_port) + off;
      if (idx >= NUM_PORTS)
        idx = idx - NUM_PORTS;                      // Wrap around
      if (!rr_found && req[idx])
      begin
        rr_found = 1'b1;                            // First hit wins
        rr_port  = PORT_W'(idx);
      end
    end
  end

  // Next grant selection
  always_comb
  begin : p_next_grant
    if (keep_owner)
    begin
      next_port    = o_addr_in_port;                // Hold owner
      next_no_port = 1'b0;
    end
    else if (rr_found)
    begin
      next_port    = rr_port;                       // Rotate
      next_no_port = 1'b0;
    end
    else
    begin
      next_port    = o_addr_in_port;                // Index kept as pointer
      next_no_port = 1'b1;
    end
  end

  // ----------------------------------------
  // Grant register
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin : p_grant_reg
    if (!HRESETn)
    begin
      o_addr_in_port <= PORT_W'(NUM_PORTS - 1);     // First grant goes to 0
      o_no_port      <= 1'b1;
    end
    else if (i_hreadymux)                           // Hold under wait states
    begin
      o_addr_in_port <= next_port;
      o_no_port      <= next_no_port;
    end
  end

endmodule
